// ==== rtl/isa_pkg.sv ====
// ISA definitions: opcode and ALU enums, instruction fields, base register numbers
`default_nettype none

package isa_pkg;

   // Top nibble of every instruction
   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_nor  = 4'd3,
      op_addi = 4'd4,
      op_sll  = 4'd5,
      op_srl  = 4'd6,
      op_lw   = 4'd8,
      op_sw   = 4'd9,
      op_b    = 4'd12,
      op_call = 4'd13,
      op_ret  = 4'd14,
      op_hlt  = 4'd15   // Codes 7, 10 and 11 stay unassigned and decode as nop
   } op_e;

   // Operation handed to the execute stage
   typedef enum logic [2:0] {
      alu_add  = 3'd0,
      alu_sub  = 3'd1,
      alu_and  = 3'd2,
      alu_nor  = 3'd3,
      alu_sll  = 3'd4,
      alu_srl  = 3'd5,
      alu_pass = 3'd6
   } alu_op_e;

   // Port 1 override toward a fixed base register
   typedef enum logic [1:0] {
      base_none  = 2'd0,
      base_data  = 2'd1,   // Data segment for lw/sw
      base_stack = 2'd2    // Stack pointer for call/ret
   } base_sel_e;

   typedef struct packed {
      op_e        opcode;
      logic [3:0] f_hi;    // rd, data reg of lw/sw, branch condition
      logic [3:0] f_mid;   // rs, or upper half of the lw/sw offset
      logic [3:0] f_lo;    // rt, imm4, or lower half of the offset
   } instr_t;

   localparam logic [3:0] data_seg_reg = 4'd14;
   localparam logic [3:0] stack_reg    = 4'd15;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
// Pipeline bundles: control signal struct and ID/EX register struct
`default_nettype none

package pipe_pkg;

   // Control levels carried down the pipe, all low for a nop or bubble
   typedef struct packed {
      logic             mem_to_reg;   // Load result goes to a register
      logic             reg_to_mem;   // Store
      logic             alu_src;      // Second ALU operand is the immediate
      isa_pkg::alu_op_e alu_op;
      logic             branch;
      logic             call;
      logic             ret;
      logic             reg_write;
      logic             halt;
   } ctrl_t;

   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      logic [15:0] read_data_1;   // rs or base register
      logic [15:0] read_data_2;   // rt, or store data for sw
      logic [15:0] imm;           // Already sign extended
      logic [3:0]  dest;
      logic [2:0]  branch_cond;
      logic [11:0] call_target;
      logic [15:0] pc;
   } id_ex_t;

endpackage

`default_nettype wire

// ==== rtl/control_decoder.sv ====
// Control decoder: opcode to control bundle, base register and operand select levels
`default_nettype none

module control_decoder (
   input  isa_pkg::op_e       opcode,
   output pipe_pkg::ctrl_t    ctrl,
   output isa_pkg::base_sel_e base_sel,
   output logic               rt_from_dest,   // Port 2 reads the store register
   output logic               imm_sel         // 8-bit offset instead of imm4
);
   import isa_pkg::*;

   always_comb begin
      // Defaults give a nop, which covers the unused codes
      ctrl         = '0;
      base_sel     = base_none;
      rt_from_dest = 1'b0;
      imm_sel      = 1'b0;
      case (opcode)
         op_add: begin
            ctrl.alu_op    = alu_add;
            ctrl.reg_write = 1'b1;
         end
         op_sub: begin
            ctrl.alu_op    = alu_sub;
            ctrl.reg_write = 1'b1;
         end
         op_and: begin
            ctrl.alu_op    = alu_and;
            ctrl.reg_write = 1'b1;
         end
         op_nor: begin
            ctrl.alu_op    = alu_nor;
            ctrl.reg_write = 1'b1;
         end
         op_addi, op_sll, op_srl: begin
            ctrl.alu_src   = 1'b1;   // Immediate in f_lo
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = (opcode == op_sll) ? alu_sll :
                             (opcode == op_srl) ? alu_srl : alu_add;
         end
         op_lw: begin
            ctrl.alu_src    = 1'b1;  // Base plus offset
            ctrl.alu_op     = alu_add;
            ctrl.mem_to_reg = 1'b1;
            ctrl.reg_write  = 1'b1;
            base_sel        = base_data;
            imm_sel         = 1'b1;
         end
         op_sw: begin
            ctrl.alu_src    = 1'b1;
            ctrl.alu_op     = alu_add;
            ctrl.reg_to_mem = 1'b1;
            base_sel        = base_data;
            rt_from_dest    = 1'b1;  // Data register sits in f_hi
            imm_sel         = 1'b1;
         end
         op_b:    ctrl.branch = 1'b1;
         op_call: begin
            ctrl.call   = 1'b1;
            ctrl.alu_op = alu_pass;   // Stack pointer passes to execute
            base_sel    = base_stack;
         end
         op_ret: begin
            ctrl.ret    = 1'b1;
            ctrl.alu_op = alu_pass;
            base_sel    = base_stack;
         end
         op_hlt:  ctrl.halt = 1'b1;
         default: ;
      endcase
   end

   // Flow change kinds exclude each other
   always_comb begin
      assert ($onehot0({ctrl.branch, ctrl.call, ctrl.ret}))
         else $error("control_decoder: more than one flow change for opcode %0d", opcode);
   end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
// Register file: two read ports, one write port, base register override, r0 tied to zero
`default_nettype none

module register_file #(
   parameter int reg_count  = 16,
   parameter int data_width = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [3:0]             rs,
   input  logic [3:0]             rt,
   input  logic [3:0]             dest,
   input  isa_pkg::base_sel_e     base_sel,
   input  logic                   rt_from_dest,
   input  logic                   wb_en,
   input  logic [3:0]             wb_reg,
   input  logic [data_width-1:0]  wb_data,
   output logic [data_width-1:0]  read_data_1,
   output logic [data_width-1:0]  read_data_2
);
   import isa_pkg::*;

   logic [data_width-1:0] regs [reg_count];
   logic [3:0]            addr_1;
   logic [3:0]            addr_2;

   // r0 first, then bypass of a same-cycle write, then the array
   function automatic logic [data_width-1:0] read_port(input logic [3:0] addr);
      if (addr == 4'd0)
         return '0;
      if (wb_en && wb_reg == addr)
         return wb_data;   // Write-through
      return regs[addr];
   endfunction

   always_comb begin
      case (base_sel)
         base_data:  addr_1 = data_seg_reg;
         base_stack: addr_1 = stack_reg;
         default:    addr_1 = rs;
      endcase
      addr_2 = rt_from_dest ? dest : rt;   // sw reads the register it stores
   end

   // Reads follow the array and the write port as well as the addresses
   always_comb begin
      read_data_1 = read_port(addr_1);
      read_data_2 = read_port(addr_2);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (wb_en && wb_reg != 4'd0) begin   // r0 writes dropped
         regs[wb_reg] <= wb_data;
      end
   end

   // Write-back index comes from outside, so keep it inside the array
   wb_reg_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      wb_en |-> (int'(wb_reg) < reg_count))
      else $error("register_file: write to register %0d out of range", wb_reg);

endmodule

`default_nettype wire

// ==== rtl/id_ex_stage.sv ====
// ID/EX stage: sign extension, load-use hazard detection, bubble insertion, ID/EX register
`default_nettype none

module id_ex_stage #(
   parameter int data_width = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  isa_pkg::instr_t        instr,
   input  logic                   instr_valid,
   input  logic [data_width-1:0]  pc,
   input  pipe_pkg::ctrl_t        ctrl,
   input  logic                   imm_sel,
   input  logic [data_width-1:0]  read_data_1,
   input  logic [data_width-1:0]  read_data_2,
   output pipe_pkg::id_ex_t       id_ex,
   output logic                   stall
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [data_width-1:0] imm_ext;
   logic                  uses_rs;      // f_mid is a source register
   logic                  uses_rt;      // f_lo is a source register
   logic                  uses_store;   // f_hi is a source register
   logic                  hazard;
   id_ex_t                bundle_d;

   // imm4 for arithmetic, {f_mid, f_lo} for lw/sw
   assign imm_ext = imm_sel ? {{(data_width-8){instr.f_mid[3]}}, instr.f_mid, instr.f_lo}
                            : {{(data_width-4){instr.f_lo[3]}}, instr.f_lo};

   always_comb begin
      uses_rs    = 1'b0;
      uses_rt    = 1'b0;
      uses_store = 1'b0;
      case (instr.opcode)
         op_add, op_sub, op_and, op_nor: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         op_addi, op_sll, op_srl: uses_rs = 1'b1;   // f_lo holds the immediate
         op_sw:                   uses_store = 1'b1;   // rs replaced by r14
         default: ;
      endcase
   end

   // Load in ID/EX whose target is read by the instruction now in ID
   always_comb begin
      hazard = 1'b0;
      if (id_ex.valid && id_ex.ctrl.mem_to_reg && id_ex.dest != 4'd0) begin
         hazard = (uses_rs    && id_ex.dest == instr.f_mid) ||
                  (uses_rt    && id_ex.dest == instr.f_lo)  ||
                  (uses_store && id_ex.dest == instr.f_hi);
      end
   end

   assign stall = instr_valid && hazard;

   always_comb begin
      bundle_d = '0;   // Bubble unless an instruction is accepted
      if (instr_valid && !stall) begin
         bundle_d.valid       = 1'b1;
         bundle_d.ctrl        = ctrl;
         bundle_d.read_data_1 = read_data_1;
         bundle_d.read_data_2 = read_data_2;
         bundle_d.imm         = imm_ext;
         bundle_d.dest        = instr.f_hi;
         bundle_d.branch_cond = instr.f_hi[2:0];
         bundle_d.call_target = {instr.f_hi, instr.f_mid, instr.f_lo};
         bundle_d.pc          = pc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         id_ex <= '0;
      else
         id_ex <= bundle_d;
   end

   // Idle or stalled cycle leaves no control bit in execute
   bubble_no_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      (!instr_valid || stall) |=> (id_ex.ctrl == '0 && !id_ex.valid))
      else $error("id_ex_stage: bubble carries control bits");

   stall_needs_instr: assert property (@(posedge clk) disable iff (!rst_n)
      stall |-> instr_valid)
      else $error("id_ex_stage: stall without a valid instruction");

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// Decode stage top: control decoder, register file and ID/EX stage
`default_nettype none

module decode_stage #(
   parameter int reg_count  = 16,
   parameter int data_width = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  isa_pkg::instr_t        instr,
   input  logic                   instr_valid,
   input  logic [data_width-1:0]  pc,
   input  logic                   wb_en,
   input  logic [3:0]             wb_reg,
   input  logic [data_width-1:0]  wb_data,
   output pipe_pkg::id_ex_t       id_ex,
   output logic                   stall
);
   import isa_pkg::*;
   import pipe_pkg::*;

   ctrl_t                 ctrl;
   base_sel_e             base_sel;
   logic                  rt_from_dest;
   logic                  imm_sel;
   logic [data_width-1:0] read_data_1;
   logic [data_width-1:0] read_data_2;

   control_decoder u_ctrl (
      .opcode       (instr.opcode),
      .ctrl         (ctrl),
      .base_sel     (base_sel),
      .rt_from_dest (rt_from_dest),
      .imm_sel      (imm_sel)
   );

   register_file #(.reg_count(reg_count), .data_width(data_width)) u_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .rs           (instr.f_mid),
      .rt           (instr.f_lo),
      .dest         (instr.f_hi),   // Store register for sw
      .base_sel     (base_sel),
      .rt_from_dest (rt_from_dest),
      .wb_en        (wb_en),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .read_data_1  (read_data_1),
      .read_data_2  (read_data_2)
   );

   id_ex_stage #(.data_width(data_width)) u_id_ex (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .pc          (pc),
      .ctrl        (ctrl),
      .imm_sel     (imm_sel),
      .read_data_1 (read_data_1),
      .read_data_2 (read_data_2),
      .id_ex       (id_ex),
      .stall       (stall)
   );

endmodule

`default_nettype wire

// ==== bench/decode_stage_tb.sv ====
// Decode stage testbench: random instructions and write-backs checked against a model
`default_nettype none

module decode_stage_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int reg_count   = 16;
   localparam int data_width  = 16;
   localparam int num_cycles  = 3000;
   localparam int stall_limit = 4;   // Longest stall run a load can cause is one

   logic        clk;
   logic        rst_n;
   instr_t      instr;
   logic        instr_valid;
   logic [15:0] pc;
   logic        wb_en;
   logic [3:0]  wb_reg;
   logic [15:0] wb_data;
   id_ex_t      id_ex;
   logic        stall;

   logic [31:0] seed;
   logic [15:0] model_regs [reg_count];
   id_ex_t      exp_bundle;   // id_ex expected after the coming edge
   logic        exp_stall;
   logic        last_stall;   // Producer view of stall, sampled at negedge
   int          errors;
   int          checks;
   int          stalls;
   int          accepted;
   int          stall_run;
   bit          timed_out;

   decode_stage #(.reg_count(reg_count), .data_width(data_width)) uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .instr_valid (instr_valid),
      .pc          (pc),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .id_ex       (id_ex),
      .stall       (stall)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // LCG step whose upper bits are the random ones
   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic instr_t random_instr();
      logic [31:0] r;
      instr_t      ins;
      r = next_rand();
      ins.opcode = (r[31:29] < 3'd3) ? op_lw : op_e'(r[28:25]);   // lw weighted up
      ins.f_hi   = r[24] ? {2'b00, r[21:20]} : r[23:20];   // Low registers often for more hazards
      ins.f_mid  = r[19] ? {2'b00, r[16:15]} : r[18:15];
      ins.f_lo   = r[14] ? {2'b00, r[11:10]} : r[13:10];
      return ins;
   endfunction

   // Decode table of the ISA
   function automatic ctrl_t expect_ctrl(input logic [3:0] op);
      ctrl_t c;
      c = '0;
      case (op)
         4'd1:         c.alu_op = alu_sub;
         4'd2:         c.alu_op = alu_and;
         4'd3:         c.alu_op = alu_nor;
         4'd5:         c.alu_op = alu_sll;
         4'd6:         c.alu_op = alu_srl;
         4'd13, 4'd14: c.alu_op = alu_pass;   // Stack pointer handed on
         default:      c.alu_op = alu_add;
      endcase
      c.reg_write  = (op <= 4'd6) || (op == 4'd8);
      c.alu_src    = (op >= 4'd4 && op <= 4'd6) || op == 4'd8 || op == 4'd9;
      c.mem_to_reg = (op == 4'd8);
      c.reg_to_mem = (op == 4'd9);
      c.branch     = (op == 4'd12);
      c.call       = (op == 4'd13);
      c.ret        = (op == 4'd14);
      c.halt       = (op == 4'd15);
      return c;
   endfunction

   function automatic logic [15:0] model_read(input logic [3:0] addr);
      if (addr == 4'd0)
         return 16'h0000;
      if (wb_en && wb_reg == addr)
         return wb_data;   // Same-cycle write seen
      return model_regs[addr];
   endfunction

   function automatic id_ex_t predict_bundle(input instr_t ins, input logic [15:0] pc_in);
      id_ex_t     b;
      logic [3:0] op;
      logic [3:0] addr_1;
      logic [3:0] addr_2;
      op     = ins.opcode;
      addr_1 = (op == 4'd8 || op == 4'd9) ? 4'd14 :
               (op == 4'd13 || op == 4'd14) ? 4'd15 : ins.f_mid;
      addr_2 = (op == 4'd9) ? ins.f_hi : ins.f_lo;   // sw stores f_hi
      b = '0;
      b.valid       = 1'b1;
      b.ctrl        = expect_ctrl(op);
      b.read_data_1 = model_read(addr_1);
      b.read_data_2 = model_read(addr_2);
      if (op == 4'd8 || op == 4'd9)
         b.imm = 16'($signed({ins.f_mid, ins.f_lo}));   // 8-bit offset
      else
         b.imm = 16'($signed(ins.f_lo));
      b.dest        = ins.f_hi;
      b.branch_cond = ins.f_hi[2:0];
      b.call_target = ins[11:0];
      b.pc          = pc_in;
      return b;
   endfunction

   // Load in ID/EX writing a register the current instruction reads
   function automatic logic predict_hazard(input instr_t ins, input id_ex_t prev);
      logic [3:0] op;
      logic       hit;
      op  = ins.opcode;
      hit = 1'b0;
      if (prev.valid && prev.ctrl.mem_to_reg && prev.dest != 4'd0) begin
         if (op <= 4'd6 && prev.dest == ins.f_mid)
            hit = 1'b1;   // rs
         if (op <= 4'd3 && prev.dest == ins.f_lo)
            hit = 1'b1;   // rt
         if (op == 4'd9 && prev.dest == ins.f_hi)
            hit = 1'b1;   // Store data
      end
      return hit;
   endfunction

   task automatic check_reset_outputs();
      checks++;
      if (id_ex.valid !== 1'b0 || id_ex.ctrl !== '0 || stall !== 1'b0) begin
         errors++;
         $display("MISMATCH at %0t: in reset valid=%b ctrl=%h stall=%b",
                  $time, id_ex.valid, id_ex.ctrl, stall);
      end
   endtask

   // Runs at negedge, where every output has settled
   task automatic check_cycle();
      checks++;
      if (id_ex !== exp_bundle) begin
         errors++;
         $display("MISMATCH at %0t: id_ex %h, expected %h", $time, id_ex, exp_bundle);
      end
      exp_stall = instr_valid && predict_hazard(instr, exp_bundle);
      if (stall !== exp_stall) begin
         errors++;
         $display("MISMATCH at %0t: stall %b, expected %b for instr %h",
                  $time, stall, exp_stall, instr);
      end
      if (exp_stall)
         stalls++;
      if (instr_valid && !exp_stall) begin
         exp_bundle = predict_bundle(instr, pc);
         accepted++;
      end else begin
         exp_bundle = '0;   // Idle or stalled cycle gives a bubble
      end
      if (wb_en && wb_reg != 4'd0)
         model_regs[wb_reg] = wb_data;   // Lands at the coming edge
      last_stall = stall;
   endtask

   initial begin
      logic [31:0] r;
      seed        = 32'hd5b2_9f9d;
      errors      = 0;
      checks      = 0;
      stalls      = 0;
      accepted    = 0;
      stall_run   = 0;
      timed_out   = 1'b0;
      last_stall  = 1'b0;
      exp_bundle  = '0;
      rst_n       = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      pc          = 16'h0000;
      wb_en       = 1'b0;
      wb_reg      = 4'd0;
      wb_data     = 16'h0000;
      for (int k = 0; k < reg_count; k++)
         model_regs[k] = 16'h0000;

      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         if (i == 15)
            rst_n <= 1'b1;
         @(negedge clk);
         check_reset_outputs();
      end

      for (int i = 0; i < num_cycles; i++) begin
         @(posedge clk);
         if (!last_stall) begin   // Held steady while stalled
            r = next_rand();
            instr_valid <= (r[31:30] != 2'd0);
            pc          <= r[23:8];
            instr       <= random_instr();
         end
         r = next_rand();
         wb_en   <= r[31];
         wb_reg  <= r[27:24];
         wb_data <= r[23:8];
         @(negedge clk);
         check_cycle();
         stall_run = stall ? stall_run + 1 : 0;
         if (stall_run > stall_limit) begin
            $display("ERROR: stall stayed high for %0d cycles, hazard never cleared", stall_run);
            timed_out = 1'b1;
            break;
         end
      end

      $display("Checks: %0d, errors: %0d, accepted: %0d, stalls: %0d",
               checks, errors, accepted, stalls);
      if (errors == 0 && !timed_out)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/id_ex_stage.sv
rtl/decode_stage.sv
bench/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module decode_stage_tb -o decode_stage_sim
./obj_dir/decode_stage_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
   echo "Simulation PASSED"
else
   echo "Simulation FAILED"
   exit 1
fi
